// File: eg_synth.f
+incdir+design
+incdir+bench
design/eg_pkg.sv
design/eg_regs.sv
design/eg_slot_seq.sv
design/eg_comb.sv
design/eg_top.sv
bench/eg_tb.sv

// File: bench/eg_tb_model.svh
`ifndef EG_TB_MODEL_SVH
`define EG_TB_MODEL_SVH

// One step of a 16-bit Galois LFSR.
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	if (s[0])
		return (s >> 1) ^ 16'hb400;
	else
		return s >> 1;
endfunction

// Collects n bits, one LFSR step per bit.
task automatic take_bits(inout logic [15:0] st, input int n, output logic [7:0] v);
	v = 8'h00;
	for (int i = 0; i < n; i++) begin
		v[i] = st[0];
		st = lfsr_step(st);
	end
endtask

// Final attenuation: level plus TL and AM depth, clamped to silence.
function automatic logic [9:0] eg_expect(input int level, input int tl, input logic amsen,
		input logic [1:0] ams, input logic [6:0] lfo);
	logic [5:0] inv;
	int depth;
	int sum;
	inv = lfo[5:0] ^ {6{lfo[6]}};
	depth = 0;
	if (amsen) begin
		case (ams)
			2'd1: depth = inv[5:2];
			2'd2: depth = inv;
			2'd3: depth = 2 * inv;
			default: depth = 0;
		endcase
	end
	sum = level + tl * 8 + depth;
	if (sum > 1023)
		sum = 1023;
	return 10'(sum);
endfunction

// Bits that each register field keeps.
function automatic logic [7:0] field_mask(input logic [2:0] f);
	case (f)
		3'd0: return 8'hdf;
		3'd1: return 8'h9f;
		3'd2: return 8'h1f;
		3'd3: return 8'hff;
		3'd4: return 8'h7f;
		3'd5: return 8'h7f;
		3'd6: return 8'h01;
		default: return 8'h00;
	endcase
endfunction

task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
	if (act !== exp)
		abort_run($sformatf("CHECK FAILED at %0t ns: %s expected 0x%0h got 0x%0h",
			$time, name, exp, act));
endtask

`endif

// File: bench/eg_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "eg_macros.svh"

module eg_tb;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int MODE_NONE = 0;
	localparam int MODE_IDLE = 1;
	localparam int MODE_FIXED = 2;
	localparam int MODE_RISE = 3;
	localparam int MODE_HOLD = 4;

	logic                   clk;
	logic                   rst;
	logic                   req;
	logic                   ack;
	logic                   we;
	logic [`EG_SLOT_W+2:0]  addr;
	logic [7:0]             wdata;
	logic [7:0]             rdata;
	logic [6:0]             lfo_mod;
	logic [`EG_LEVEL_W-1:0] eg_out;
	logic [`EG_SLOT_W-1:0]  eg_out_slot;
	logic                   eg_valid;

	int                     errors;
	int                     slot_mode [`EG_SLOTS];
	logic [`EG_LEVEL_W-1:0] last_out [`EG_SLOTS];
	logic [`EG_LEVEL_W-1:0] hold_val;
	logic [6:0]             sh_tl;
	logic                   sh_amsen;
	logic [1:0]             sh_ams;
	logic [15:0]            reg_st;
	logic [15:0]            lfo_st;

	task automatic abort_run(input string msg);
		errors++;
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	`include "eg_tb_model.svh"

	eg_top u_dut (
		.clk(clk), .rst(rst), .req(req), .ack(ack), .we(we), .addr(addr),
		.wdata(wdata), .rdata(rdata), .lfo_mod(lfo_mod), .eg_out(eg_out),
		.eg_out_slot(eg_out_slot), .eg_valid(eg_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		wait_cycles(16);
		rst = 1'b0;
	endtask

	// Four-phase handshake that returns rdata captured while ack is high.
	task automatic host_xfer(input logic w, input logic [4:0] a, input logic [7:0] d,
			output logic [7:0] q);
		check_val("ack idle", ack, 1'b0);
		addr = a;
		wdata = d;
		we = w;
		req = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (ack !== 1'b1);
		q = rdata;
		req = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (ack !== 1'b0);
		we = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] s, input logic [2:0] f, input logic [7:0] d);
		logic [7:0] unused;
		host_xfer(1'b1, {s, f}, d, unused);
	endtask

	task automatic read_reg(input logic [1:0] s, input logic [2:0] f, output logic [7:0] q);
		host_xfer(1'b0, {s, f}, 8'h00, q);
	endtask

	// New AM input every cycle.
	initial begin
		logic [7:0] b;
		lfo_mod = 7'd0;
		lfo_st = 16'd33;
		forever begin
			@(posedge clk);
			#1;
			take_bits(lfo_st, 7, b);
			lfo_mod = b[6:0];
		end
	end

	initial begin : compare_outputs
		int exp_slot;
		logic [6:0] prev_lfo;
		logic [1:0] s;
		logic rst_seen;
		exp_slot = 0;
		prev_lfo = 7'd0;
		forever begin
			@(posedge clk);
			// Reset as the output registers saw it.
			rst_seen = rst;
			@(negedge clk);
			check_val("eg_valid", eg_valid, !rst_seen);
			if (rst_seen) begin
				exp_slot = 0;
			end else begin
				s = eg_out_slot;
				check_val("eg_out_slot", eg_out_slot, exp_slot);
				exp_slot = (exp_slot + 1) % `EG_SLOTS;
				case (slot_mode[s])
					MODE_IDLE: check_val("eg_out idle", eg_out, 10'h3ff);
					MODE_FIXED: check_val("eg_out", eg_out,
						eg_expect(0, sh_tl, sh_amsen, sh_ams, prev_lfo));
					MODE_RISE: check_val("eg_out rising", eg_out >= last_out[s], 1'b1);
					MODE_HOLD: check_val("eg_out sustain", eg_out, hold_val);
					default: ;
				endcase
				last_out[s] = eg_out;
			end
			// AM input seen by the visit that the next output reports.
			prev_lfo = lfo_mod;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
				abort_run("Timeout: the run did not finish within the cycle limit.");
		end
	end

	initial begin
		logic [7:0] d;
		logic [7:0] q;
		errors = 0;
		rst = 1'b1;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = 8'h00;
		reg_st = 16'd33;
		sh_tl = 7'd0;
		sh_amsen = 1'b0;
		sh_ams = 2'd0;
		hold_val = '1;
		for (int i = 0; i < `EG_SLOTS; i++) begin
			slot_mode[i] = MODE_NONE;
			last_out[i] = '1;
		end
		#1;
		apply_reset();

		// All slots silent after reset.
		for (int i = 0; i < `EG_SLOTS; i++)
			slot_mode[i] = MODE_IDLE;
		wait_cycles(40);

		// Register read-back.
		for (int i = 0; i < `EG_SLOTS; i++)
			slot_mode[i] = MODE_NONE;
		for (int s = 0; s < `EG_SLOTS; s++) begin
			for (int f = 0; f < 8; f++) begin
				take_bits(reg_st, 8, d);
				write_reg(s[1:0], f[2:0], d);
				read_reg(s[1:0], f[2:0], q);
				check_val("rdata", q, d & field_mask(f[2:0]));
			end
		end

		// Random key-on values above leave slots running.
		apply_reset();
		for (int i = 1; i < `EG_SLOTS; i++)
			slot_mode[i] = MODE_IDLE;

		// Instant attack on slot 0.
		write_reg(2'd0, 3'd0, 8'h1f);
		write_reg(2'd0, 3'd6, 8'h01);
		for (int r = 0; r < 6; r++) begin
			slot_mode[0] = MODE_NONE;
			if (r == 0) begin
				sh_tl = 7'h7f;
				sh_amsen = 1'b1;
				sh_ams = 2'd3;
			end else begin
				take_bits(reg_st, 7, d);
				sh_tl = d[6:0];
				take_bits(reg_st, 1, d);
				sh_amsen = d[0];
				take_bits(reg_st, 2, d);
				sh_ams = d[1:0];
			end
			write_reg(2'd0, 3'd4, {1'b0, sh_tl});
			write_reg(2'd0, 3'd1, {sh_amsen, 7'd0});
			write_reg(2'd0, 3'd5, {1'b0, sh_ams, 5'd0});
			wait_cycles(8);
			slot_mode[0] = MODE_FIXED;
			wait_cycles(40);
		end

		// Decay to sustain level 4 * 32.
		slot_mode[0] = MODE_NONE;
		write_reg(2'd0, 3'd4, 8'h00);
		write_reg(2'd0, 3'd1, 8'd20);
		write_reg(2'd0, 3'd2, 8'h00);
		write_reg(2'd0, 3'd3, 8'h4f);
		write_reg(2'd0, 3'd5, 8'h00);
		write_reg(2'd0, 3'd6, 8'h00);
		wait_cycles(8);
		write_reg(2'd0, 3'd6, 8'h01);
		wait_cycles(8);
		slot_mode[0] = MODE_RISE;
		while (last_out[0] < 10'd128)
			wait_cycles(1);
		wait_cycles(8);
		check_val("sustain level in range", last_out[0] >= 10'd128 && last_out[0] <= 10'd130,
			1'b1);
		hold_val = last_out[0];
		slot_mode[0] = MODE_HOLD;
		wait_cycles(200);

		// Release to silence.
		slot_mode[0] = MODE_RISE;
		write_reg(2'd0, 3'd6, 8'h00);
		while (last_out[0] != 10'h3ff)
			wait_cycles(1);
		slot_mode[0] = MODE_IDLE;
		wait_cycles(40);

		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/eg_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "eg_macros.svh"

module eg_top import eg_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req,
	output logic                   ack,
	input  logic                   we,
	input  logic [`EG_SLOT_W+2:0]  addr,
	input  logic [7:0]             wdata,
	output logic [7:0]             rdata,
	input  logic [6:0]             lfo_mod,
	output logic [`EG_LEVEL_W-1:0] eg_out,
	output logic [`EG_SLOT_W-1:0]  eg_out_slot,
	output logic                   eg_valid
);

	logic [`EG_SLOT_W-1:0]  slot;
	logic [4:0]             ar, d1r, d2r, keycode, arate, base_rate, keycode_s;
	logic [3:0]             rr, sl;
	logic [1:0]             ks, ams, ks_s, ams_s;
	logic [6:0]             tl, tl_s;
	logic                   amsen, keyon, amsen_s, cnt_in, cnt_lsb;
	eg_state_e              state;
	logic [`EG_CNT_W-1:0]   eg_cnt;
	logic [`EG_LEVEL_W-1:0] eg_in, eg_pure_next, eg_limited;

	eg_regs u_regs (
		.clk(clk), .rst(rst), .req(req), .ack(ack), .we(we), .addr(addr),
		.wdata(wdata), .rdata(rdata), .slot(slot), .ar(ar), .d1r(d1r),
		.d2r(d2r), .rr(rr), .sl(sl), .ks(ks), .keycode(keycode), .tl(tl),
		.amsen(amsen), .ams(ams), .keyon(keyon)
	);

	eg_slot_seq u_seq (
		.clk(clk), .rst(rst), .ar(ar), .d1r(d1r), .d2r(d2r), .rr(rr), .sl(sl),
		.ks(ks), .keycode(keycode), .tl(tl), .amsen(amsen), .ams(ams),
		.keyon(keyon), .slot(slot), .state(state), .arate(arate),
		.base_rate(base_rate), .keycode_o(keycode_s), .eg_cnt(eg_cnt),
		.cnt_in(cnt_in), .ks_o(ks_s), .eg_in(eg_in), .amsen_o(amsen_s),
		.ams_o(ams_s), .tl_o(tl_s), .eg_pure_next(eg_pure_next), .cnt_lsb(cnt_lsb)
	);

	eg_comb u_comb (
		.state(state), .arate(arate), .base_rate(base_rate), .keycode(keycode_s),
		.eg_cnt(eg_cnt), .cnt_in(cnt_in), .ks(ks_s), .eg_in(eg_in),
		.lfo_mod(lfo_mod), .amsen(amsen_s), .ams(ams_s), .tl(tl_s),
		.cnt_lsb(cnt_lsb), .eg_limited(eg_limited), .eg_pure_next(eg_pure_next)
	);

	always_ff @(posedge clk) begin
		if (rst)
			eg_valid <= 1'b0;
		else
			eg_valid <= 1'b1;
	end

	// One cycle behind the slot visit.
	always_ff @(posedge clk) begin
		eg_out <= eg_limited;
		eg_out_slot <= slot;
	end

endmodule

`default_nettype wire

// File: design/eg_comb.sv
`timescale 1ns/1ns
`default_nettype none

`include "eg_macros.svh"

module eg_comb import eg_pkg::*; (
	input  eg_state_e              state,
	input  logic [4:0]             arate,
	input  logic [4:0]             base_rate,
	input  logic [4:0]             keycode,
	input  logic [`EG_CNT_W-1:0]   eg_cnt,
	input  logic                   cnt_in,
	input  logic [1:0]             ks,
	input  logic [`EG_LEVEL_W-1:0] eg_in,
	input  logic [6:0]             lfo_mod,
	input  logic                   amsen,
	input  logic [1:0]             ams,
	input  logic [6:0]             tl,
	output logic                   cnt_lsb,
	output logic [`EG_LEVEL_W-1:0] eg_limited,
	output logic [`EG_LEVEL_W-1:0] eg_pure_next
);

	logic                    attack;
	logic                    ar_off;
	logic [1:0]              ks_shift;
	logic [4:0]              kc_scaled;
	logic [6:0]              pre_rate;
	logic [5:0]              rate;
	logic [3:0]              cnt_shift;
	logic [`EG_CNT_W-1:0]    cnt_sel;
	logic [2:0]              cnt;
	logic [7:0]              pattern;
	logic                    step;
	logic                    sum_up;
	logic [3:0]              dec_inc;
	logic [`EG_LEVEL_W:0]    dec_sum;
	logic [7:0]              ar_base;
	logic [8:0]              ar_sum0;
	logic [`EG_LEVEL_W-1:0]  ar_sum;
	logic [`EG_LEVEL_W-1:0]  ar_result;
	logic [5:0]              am_inv;
	logic [6:0]              am_depth;
	logic [`EG_LEVEL_W+1:0]  total;

	assign attack = state == EG_ATTACK;
	assign ar_off = attack && arate == 5'h1f;

	// Key scaling adds keycode >> (3 - ks).
	always_comb begin
		ks_shift = 2'd3 - ks;
		kc_scaled = keycode >> ks_shift;
		if (base_rate == 5'd0)
			pre_rate = 7'd0;
		else
			pre_rate = {1'b0, base_rate, 1'b0} + {2'b0, kc_scaled};
		rate = pre_rate[6] ? 6'd63 : pre_rate[5:0];
	end

	// Attack runs one counter bit faster than decay.
	always_comb begin
		if (attack)
			cnt_shift = (rate[5:2] >= 4'd11) ? 4'd0 : 4'd11 - rate[5:2];
		else
			cnt_shift = (rate[5:2] >= 4'd12) ? 4'd0 : 4'd12 - rate[5:2];
		cnt_sel = eg_cnt >> cnt_shift;
		cnt = cnt_sel[2:0];
	end

	always_comb begin
		if (rate[5:4] == 2'b11) begin
			if (attack && rate[5:2] == 4'hf)
				pattern = 8'hff;
			else begin
				case (rate[1:0])
					2'd0: pattern = 8'b0000_0000;
					2'd1: pattern = 8'b1000_1000;
					2'd2: pattern = 8'b1010_1010;
					default: pattern = 8'b1110_1110;
				endcase
			end
		end else if (!attack && rate[5:2] == 4'd0) begin
			pattern = 8'b1111_1110;
		end else begin
			case (rate[1:0])
				2'd0: pattern = 8'b1010_1010;
				2'd1: pattern = 8'b1110_1010;
				2'd2: pattern = 8'b1110_1110;
				default: pattern = 8'b1111_1110;
			endcase
		end
		step = (rate[5:1] == 5'd0) ? 1'b0 : pattern[cnt];
	end

	// Update only when the selected counter bit has toggled.
	assign cnt_lsb = cnt[0];
	assign sum_up = cnt[0] != cnt_in;

	always_comb begin
		case (rate[5:2])
			4'd12: dec_inc = {2'b0, step, ~step};
			4'd13: dec_inc = {1'b0, step, ~step, 1'b0};
			4'd14: dec_inc = {step, ~step, 2'b0};
			4'd15: dec_inc = 4'd8;
			default: dec_inc = {2'b0, step, 1'b0};
		endcase
		dec_sum = {1'b0, eg_in} + {7'b0, dec_inc};
	end

	// Exponential attack, a fraction of the current level.
	always_comb begin
		case (rate[5:2])
			4'd13: ar_base = {1'b0, eg_in[9:3]};
			4'd14, 4'd15: ar_base = eg_in[9:2];
			default: ar_base = {2'b0, eg_in[9:4]};
		endcase
		ar_sum0 = {1'b0, ar_base} + 9'd1;
		if (rate[5:4] == 2'b11)
			ar_sum = step ? {ar_sum0, 1'b0} : {1'b0, ar_sum0};
		else
			ar_sum = step ? {1'b0, ar_sum0} : '0;
		ar_result = (ar_sum < eg_in) ? eg_in - ar_sum : '0;
	end

	always_comb begin
		if (ar_off)
			eg_pure_next = '0;
		else if (attack) begin
			if (sum_up && eg_in != '0)
				eg_pure_next = (rate[5:1] == 5'h1f) ? '0 : ar_result;
			else
				eg_pure_next = eg_in;
		end else if (sum_up)
			eg_pure_next = dec_sum[`EG_LEVEL_W] ? '1 : dec_sum[`EG_LEVEL_W-1:0];
		else
			eg_pure_next = eg_in;
	end

	// Triangle LFO folded to a 6-bit depth.
	always_comb begin
		am_inv = {6{lfo_mod[6]}} ^ lfo_mod[5:0];
		am_depth = 7'd0;
		if (amsen) begin
			case (ams)
				2'd1: am_depth = {3'b0, am_inv[5:2]};
				2'd2: am_depth = {1'b0, am_inv};
				2'd3: am_depth = {am_inv, 1'b0};
				default: am_depth = 7'd0;
			endcase
		end
		total = {2'b0, eg_pure_next} + {2'b0, tl, 3'b0} + {5'b0, am_depth};
	end

	assign eg_limited = (total[`EG_LEVEL_W+1:`EG_LEVEL_W] == 2'b0) ?
		total[`EG_LEVEL_W-1:0] : '1;

endmodule

`default_nettype wire

// File: design/eg_slot_seq.sv
`timescale 1ns/1ns
`default_nettype none

`include "eg_macros.svh"

module eg_slot_seq import eg_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [4:0]             ar,
	input  logic [4:0]             d1r,
	input  logic [4:0]             d2r,
	input  logic [3:0]             rr,
	input  logic [3:0]             sl,
	input  logic [1:0]             ks,
	input  logic [4:0]             keycode,
	input  logic [6:0]             tl,
	input  logic                   amsen,
	input  logic [1:0]             ams,
	input  logic                   keyon,
	output logic [`EG_SLOT_W-1:0]  slot,
	output eg_state_e              state,
	output logic [4:0]             arate,
	output logic [4:0]             base_rate,
	output logic [4:0]             keycode_o,
	output logic [`EG_CNT_W-1:0]   eg_cnt,
	output logic                   cnt_in,
	output logic [1:0]             ks_o,
	output logic [`EG_LEVEL_W-1:0] eg_in,
	output logic                   amsen_o,
	output logic [1:0]             ams_o,
	output logic [6:0]             tl_o,
	input  logic [`EG_LEVEL_W-1:0] eg_pure_next,
	input  logic                   cnt_lsb
);

	eg_state_e               state_mem [`EG_SLOTS];
	logic [`EG_LEVEL_W-1:0]  level_mem [`EG_SLOTS];
	logic                    keyon_mem [`EG_SLOTS];
	logic                    cnt_mem   [`EG_SLOTS];

	logic                    key_rise;
	logic                    key_fall;
	logic [`EG_LEVEL_W-1:0]  sus_level;
	eg_state_e               next_state;

	assign key_rise = keyon & ~keyon_mem[slot];
	assign key_fall = ~keyon & keyon_mem[slot];
	assign sus_level = {1'b0, sl, 5'd0};

	// Key events override the stored phase for this visit.
	always_comb begin
		if (key_rise)
			state = EG_ATTACK;
		else if (key_fall)
			state = EG_RELEASE;
		else
			state = state_mem[slot];
	end

	always_comb begin
		case (state)
			EG_ATTACK:  base_rate = ar;
			EG_DECAY1:  base_rate = d1r;
			EG_DECAY2:  base_rate = d2r;
			default:    base_rate = {rr, 1'b1};
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			EG_ATTACK:
				if (eg_pure_next == '0)
					next_state = EG_DECAY1;
			EG_DECAY1:
				if (eg_pure_next >= sus_level)
					next_state = EG_DECAY2;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
			eg_cnt <= '0;
		end else begin
			slot <= slot + 1'b1;
			// Counter ticks once per full round of slots.
			if (slot == `EG_SLOT_W'(`EG_SLOTS - 1))
				eg_cnt <= eg_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `EG_SLOTS; i++) begin
				state_mem[i] <= EG_RELEASE;
				level_mem[i] <= '1;
				keyon_mem[i] <= 1'b0;
				cnt_mem[i] <= 1'b0;
			end
		end else begin
			state_mem[slot] <= next_state;
			level_mem[slot] <= eg_pure_next;
			keyon_mem[slot] <= keyon;
			cnt_mem[slot] <= cnt_lsb;
		end
	end

	assign arate = ar;
	assign cnt_in = cnt_mem[slot];
	assign eg_in = level_mem[slot];
	assign keycode_o = keycode;
	assign ks_o = ks;
	assign amsen_o = amsen;
	assign ams_o = ams;
	assign tl_o = tl;

endmodule

`default_nettype wire

// File: design/eg_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "eg_macros.svh"

module eg_regs import eg_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 req,
	output logic                 ack,
	input  logic                 we,
	input  logic [`EG_SLOT_W+2:0] addr,
	input  logic [7:0]           wdata,
	output logic [7:0]           rdata,
	input  logic [`EG_SLOT_W-1:0] slot,
	output logic [4:0]           ar,
	output logic [4:0]           d1r,
	output logic [4:0]           d2r,
	output logic [3:0]           rr,
	output logic [3:0]           sl,
	output logic [1:0]           ks,
	output logic [4:0]           keycode,
	output logic [6:0]           tl,
	output logic                 amsen,
	output logic [1:0]           ams,
	output logic                 keyon
);

	logic [4:0] ar_r      [`EG_SLOTS];
	logic [4:0] d1r_r     [`EG_SLOTS];
	logic [4:0] d2r_r     [`EG_SLOTS];
	logic [3:0] rr_r      [`EG_SLOTS];
	logic [3:0] sl_r      [`EG_SLOTS];
	logic [1:0] ks_r      [`EG_SLOTS];
	logic [4:0] keycode_r [`EG_SLOTS];
	logic [6:0] tl_r      [`EG_SLOTS];
	logic       amsen_r   [`EG_SLOTS];
	logic [1:0] ams_r     [`EG_SLOTS];
	logic       keyon_r   [`EG_SLOTS];

	eg_field_e             field;
	logic [`EG_SLOT_W-1:0] hslot;
	logic [7:0]            rd_byte;
	logic                  start;

	assign field = eg_field_e'(addr[2:0]);
	assign hslot = addr[`EG_SLOT_W+2:3];
	// New request while idle.
	assign start = req & ~ack;

	always_ff @(posedge clk) begin
		if (rst)
			ack <= 1'b0;
		else if (start)
			ack <= 1'b1;
		else if (ack && !req)
			ack <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `EG_SLOTS; i++) begin
				ar_r[i] <= '0;
				d1r_r[i] <= '0;
				d2r_r[i] <= '0;
				rr_r[i] <= '0;
				sl_r[i] <= '0;
				ks_r[i] <= '0;
				keycode_r[i] <= '0;
				tl_r[i] <= '0;
				amsen_r[i] <= 1'b0;
				ams_r[i] <= '0;
				keyon_r[i] <= 1'b0;
			end
		end else if (start && we) begin
			case (field)
				REG_AR_KS: begin
					ar_r[hslot] <= wdata[4:0];
					ks_r[hslot] <= wdata[7:6];
				end
				REG_D1R_AMSEN: begin
					d1r_r[hslot] <= wdata[4:0];
					amsen_r[hslot] <= wdata[7];
				end
				REG_D2R: d2r_r[hslot] <= wdata[4:0];
				REG_RR_SL: begin
					rr_r[hslot] <= wdata[3:0];
					sl_r[hslot] <= wdata[7:4];
				end
				REG_TL: tl_r[hslot] <= wdata[6:0];
				REG_KC_AMS: begin
					keycode_r[hslot] <= wdata[4:0];
					ams_r[hslot] <= wdata[6:5];
				end
				REG_KEYON: keyon_r[hslot] <= wdata[0];
				default: ;
			endcase
		end
	end

	// Read-back, undefined bits as zero.
	always_comb begin
		case (field)
			REG_AR_KS:     rd_byte = {ks_r[hslot], 1'b0, ar_r[hslot]};
			REG_D1R_AMSEN: rd_byte = {amsen_r[hslot], 2'b0, d1r_r[hslot]};
			REG_D2R:       rd_byte = {3'b0, d2r_r[hslot]};
			REG_RR_SL:     rd_byte = {sl_r[hslot], rr_r[hslot]};
			REG_TL:        rd_byte = {1'b0, tl_r[hslot]};
			REG_KC_AMS:    rd_byte = {1'b0, ams_r[hslot], keycode_r[hslot]};
			REG_KEYON:     rd_byte = {7'b0, keyon_r[hslot]};
			default:       rd_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (start && !we)
			rdata <= rd_byte;
	end

	assign ar = ar_r[slot];
	assign d1r = d1r_r[slot];
	assign d2r = d2r_r[slot];
	assign rr = rr_r[slot];
	assign sl = sl_r[slot];
	assign ks = ks_r[slot];
	assign keycode = keycode_r[slot];
	assign tl = tl_r[slot];
	assign amsen = amsen_r[slot];
	assign ams = ams_r[slot];
	assign keyon = keyon_r[slot];

endmodule

`default_nettype wire

// File: design/eg_pkg.sv
`default_nettype none

package eg_pkg;

	// Envelope phase of one slot.
	typedef enum logic [2:0] {
		EG_ATTACK  = 3'd0,
		EG_DECAY1  = 3'd1,
		EG_DECAY2  = 3'd2,
		EG_RELEASE = 3'd3
	} eg_state_e;

	// Register field, low three address bits.
	typedef enum logic [2:0] {
		REG_AR_KS     = 3'd0,
		REG_D1R_AMSEN = 3'd1,
		REG_D2R       = 3'd2,
		REG_RR_SL     = 3'd3,
		REG_TL        = 3'd4,
		REG_KC_AMS    = 3'd5,
		REG_KEYON     = 3'd6
	} eg_field_e;

endpackage

`default_nettype wire

// File: design/eg_macros.svh
`ifndef EG_MACROS_SVH
`define EG_MACROS_SVH

// Operator slots sharing one envelope datapath.
`define EG_SLOTS 4

// Slot index width.
`define EG_SLOT_W 2

// Global envelope counter width.
`define EG_CNT_W 15

// Attenuation width, 0 is loudest and all ones is silent.
`define EG_LEVEL_W 10

`endif
